//--- design/game_pkg.sv
`default_nettype none

package game_pkg;

	////////////////////////////////////////////////////////////
	// board cells and players

	typedef logic [1:0] cell_t;		// one board position
	typedef logic [2:0] col_t;		// column picked by a player
	typedef logic [1:0] resp_t;

	localparam cell_t CELL_EMPTY = 2'd0;
	localparam cell_t CELL_P1    = 2'd1;
	localparam cell_t CELL_P2    = 2'd2;

	////////////////////////////////////////////////////////////
	// answers to a move

	localparam resp_t RESP_NONE   = 2'd0;
	localparam resp_t RESP_REJECT = 2'd1;	// column already full
	localparam resp_t RESP_ACCEPT = 2'd2;

	typedef struct packed
	{
		col_t  col;
		cell_t player;
	} move_t;

endpackage

`default_nettype wire

//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;
	import game_pkg::*;

	typedef logic [5:0] addr_t;		// cell address, board of up to 64 cells

	// one port cycle toward the row memory
	typedef struct packed
	{
		addr_t addr;
		cell_t data;
		logic  rden;
		logic  wren;
	} mem_req_t;

	// board update toward the local copy
	typedef struct packed
	{
		logic  load;	// whole row from data_in
		logic  write;	// single cell
		logic  clear;
		addr_t index;	// row base on load, cell on write
		cell_t data;
	} shadow_op_t;

endpackage

`default_nettype wire

//--- design/move_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module move_fsm
	import game_pkg::*;
	import mem_pkg::*;
#(
	parameter int NUM_ROWS = 6,
	parameter int NUM_COLS = 7
)
(
	input  wire logic                             clk,
	input  wire logic                             reset,
	input  wire logic                             active,
	input  wire move_t                            move,
	input  wire logic                             ready,
	input  wire logic [2*NUM_ROWS*NUM_COLS-1:0]   board,
	input  wire logic                             p1_win,
	input  wire logic                             p2_win,
	output mem_req_t                              mem_req,
	output shadow_op_t                            shadow_op,
	output resp_t                                 response
);

	localparam int    NUM_CELLS  = NUM_ROWS * NUM_COLS;
	localparam addr_t BOTTOM_ROW = addr_t'((NUM_ROWS - 1) * NUM_COLS);	// base 35 on 6x7

	typedef logic [$bits(addr_t):0] count_t;	// one bit wider, reaches NUM_CELLS

	typedef enum logic [3:0]
	{
		idle, capture, rd_setup, rd_wait, check, wr_setup, wr_wait, respond,
		victory, won, won_setup, won_wait, clear, clr_setup, clr_wait
	} state_t;

	state_t state;
	state_t next_state;
	move_t  cur_move;		// move being played
	addr_t  row_base;		// row currently examined
	count_t sweep_cnt;		// next address of a clear or won sweep
	logic   accepted;
	cell_t  winner;
	addr_t  target;
	cell_t  target_cell;

	assign target      = row_base + addr_t'(cur_move.col);
	assign target_cell = board[2*target +: 2];

	////////////////////////////////////////////////////////////
	// next state

	always_comb
	begin
		next_state = state;
		case (state)
			idle:
				if (active)
					next_state = capture;
			capture:   next_state = rd_setup;
			rd_setup:  next_state = rd_wait;
			rd_wait:
				if (ready)
					next_state = check;
			check:
			begin
				if (target_cell == CELL_EMPTY)
					next_state = wr_setup;
				else if (row_base != '0)
					next_state = rd_setup;	// one row up
				else
					next_state = respond;	// top row taken, column full
			end
			wr_setup:  next_state = wr_wait;
			wr_wait:
				if (ready)
					next_state = respond;
			respond:   next_state = victory;
			victory:
				if (p1_win || p2_win)
					next_state = won;
				else
					next_state = idle;
			won:
				if (sweep_cnt < NUM_CELLS)
					next_state = won_setup;	// stays here once painted
			won_setup: next_state = won_wait;
			won_wait:
				if (ready)
					next_state = won;
			clear:
				if (sweep_cnt < NUM_CELLS)
					next_state = clr_setup;
				else
					next_state = idle;
			clr_setup: next_state = clr_wait;
			clr_wait:
				if (ready)
					next_state = clear;
			default:   next_state = clear;
		endcase
	end

	////////////////////////////////////////////////////////////
	// control registers

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			state     <= clear;
			row_base  <= BOTTOM_ROW;
			sweep_cnt <= '0;
			accepted  <= 1'b0;
			winner    <= CELL_EMPTY;
		end
		else
		begin
			state <= next_state;
			case (state)
				capture:
				begin
					row_base <= BOTTOM_ROW;	// scan starts at the bottom
					accepted <= 1'b0;
				end
				check:
				begin
					if (target_cell == CELL_EMPTY)
						accepted <= 1'b1;
					else if (row_base != '0)
						row_base <= row_base - addr_t'(NUM_COLS);
				end
				victory:
				begin
					sweep_cnt <= '0;
					winner    <= p1_win ? CELL_P1 : CELL_P2;
				end
				won_wait, clr_wait:
					if (ready)
						sweep_cnt <= sweep_cnt + 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == capture)
			cur_move <= move;
	end

	////////////////////////////////////////////////////////////
	// memory port, board updates and answer

	always_comb
	begin
		mem_req   = '0;
		response  = RESP_NONE;
		shadow_op = '0;
		case (state)
			rd_setup, rd_wait:
			begin
				mem_req.addr = row_base;
				mem_req.rden = (state == rd_wait);	// config cycle has no strobe
			end
			wr_setup, wr_wait:
			begin
				mem_req.addr = target;
				mem_req.data = cur_move.player;
				mem_req.wren = (state == wr_wait);
			end
			won_setup, won_wait:
			begin
				mem_req.addr = addr_t'(sweep_cnt);
				mem_req.data = winner;
				mem_req.wren = (state == won_wait);
			end
			clr_setup, clr_wait:
			begin
				mem_req.addr = addr_t'(sweep_cnt);
				mem_req.data = CELL_EMPTY;
				mem_req.wren = (state == clr_wait);
			end
			respond:
				response = accepted ? RESP_ACCEPT : RESP_REJECT;
			default: ;
		endcase

		shadow_op.load  = (state == rd_wait) && ready;	// row lands with ready
		shadow_op.write = (state == wr_setup);
		shadow_op.clear = (state == clear) || (state == clr_setup) || (state == clr_wait);
		shadow_op.index = (state == wr_setup) ? target : row_base;
		shadow_op.data  = cur_move.player;
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (!reset)
		!(mem_req.rden && mem_req.wren));

	a_addr_range: assert property (@(posedge clk) disable iff (!reset)
		(mem_req.rden || mem_req.wren) |-> (int'(mem_req.addr) < NUM_CELLS));

	a_col_range: assert property (@(posedge clk) disable iff (!reset)
		(state == capture) |-> (int'(move.col) < NUM_COLS));

endmodule

`default_nettype wire

//--- design/board_shadow.sv
`timescale 1ns/1ps
`default_nettype none

module board_shadow
	import mem_pkg::*;
#(
	parameter int NUM_ROWS = 6,
	parameter int NUM_COLS = 7
)
(
	input  wire logic                           clk,
	input  wire logic                           reset,
	input  wire shadow_op_t                     shadow_op,
	input  wire logic [2*NUM_COLS-1:0]          data_in,
	output logic [2*NUM_ROWS*NUM_COLS-1:0]      board
);

	localparam int ROW_W = 2 * NUM_COLS;	// one memory word

	////////////////////////////////////////////////////////////
	// cell store
	// cell i lives at bits 2i+1:2i, row r starts at cell r*NUM_COLS
	// row 0 is the top of the board

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			board <= '0;
		end
		else if (shadow_op.clear)
		begin
			board <= '0;			// held through the clear sweep
		end
		else if (shadow_op.load)
		begin
			board[2*shadow_op.index +: ROW_W] <= data_in;	// refresh whole row
		end
		else if (shadow_op.write)
		begin
			board[2*shadow_op.index +: 2] <= shadow_op.data;
		end
	end

	// a row read and a cell write never overlap in one move
	a_no_load_write: assert property (@(posedge clk) disable iff (!reset)
		!(shadow_op.load && shadow_op.write));

endmodule

`default_nettype wire

//--- design/win_detect.sv
`timescale 1ns/1ps
`default_nettype none

module win_detect
	import game_pkg::*;
#(
	parameter int NUM_ROWS = 6,
	parameter int NUM_COLS = 7
)
(
	input  wire logic                           clk,
	input  wire logic                           reset,
	input  wire logic [2*NUM_ROWS*NUM_COLS-1:0] board,
	output logic                                p1_win,
	output logic                                p2_win
);

	// index 0 for player one, 1 for player two
	logic [1:0][NUM_ROWS-1:0][NUM_COLS-1:0] own;	// cell holds that player's code
	logic [1:0][NUM_ROWS-1:0][NUM_COLS-1:0] horiz;	// run starting at r,c going right
	logic [1:0][NUM_ROWS-1:0][NUM_COLS-1:0] vert;	// going down
	logic [1:0][NUM_ROWS-1:0][NUM_COLS-1:0] fall;	// down and right
	logic [1:0][NUM_ROWS-1:0][NUM_COLS-1:0] rise;	// down and left

	////////////////////////////////////////////////////////////
	// all runs of four, 69 per player on a 6x7 board

	for (genvar p = 0; p < 2; p++)
	begin : g_player
		localparam cell_t CODE = (p == 0) ? CELL_P1 : CELL_P2;
		for (genvar r = 0; r < NUM_ROWS; r++)
		begin : g_row
			for (genvar c = 0; c < NUM_COLS; c++)
			begin : g_col
				assign own[p][r][c] = (board[2*(r*NUM_COLS+c) +: 2] == CODE);

				if (c <= NUM_COLS - 4)
					assign horiz[p][r][c] = &own[p][r][c+3:c];
				else
					assign horiz[p][r][c] = 1'b0;

				if (r <= NUM_ROWS - 4)
					assign vert[p][r][c] = own[p][r][c] & own[p][r+1][c] &
						own[p][r+2][c] & own[p][r+3][c];
				else
					assign vert[p][r][c] = 1'b0;

				if (r <= NUM_ROWS - 4 && c <= NUM_COLS - 4)
					assign fall[p][r][c] = own[p][r][c] & own[p][r+1][c+1] &
						own[p][r+2][c+2] & own[p][r+3][c+3];
				else
					assign fall[p][r][c] = 1'b0;

				if (r <= NUM_ROWS - 4 && c >= 3)
					assign rise[p][r][c] = own[p][r][c] & own[p][r+1][c-1] &
						own[p][r+2][c-2] & own[p][r+3][c-3];
				else
					assign rise[p][r][c] = 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			p1_win <= 1'b0;
			p2_win <= 1'b0;
		end
		else
		begin
			p1_win <= |{horiz[0], vert[0], fall[0], rise[0]};
			p2_win <= |{horiz[1], vert[1], fall[1], rise[1]};
		end
	end

endmodule

`default_nettype wire

//--- design/connect4_top.sv
`timescale 1ns/1ps
`default_nettype none

module connect4_top
	import game_pkg::*;
	import mem_pkg::*;
#(
	parameter int NUM_ROWS = 6,
	parameter int NUM_COLS = 7
)
(
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  active,	// level, only looked at in idle
	input  wire move_t                 move,
	input  wire logic                  ready,	// one-cycle pulse from memory
	input  wire logic [2*NUM_COLS-1:0] data_in,	// row word, valid with ready
	output mem_req_t                   mem_req,
	output resp_t                      response
);

	shadow_op_t                     shadow_op;
	logic [2*NUM_ROWS*NUM_COLS-1:0] board;		// flat copy, cell i at bits 2i+1:2i
	logic                           p1_win;
	logic                           p2_win;

	move_fsm #(.NUM_ROWS(NUM_ROWS), .NUM_COLS(NUM_COLS)) u_move_fsm
	(
		.clk       (clk),
		.reset     (reset),
		.active    (active),
		.move      (move),
		.ready     (ready),
		.board     (board),
		.p1_win    (p1_win),
		.p2_win    (p2_win),
		.mem_req   (mem_req),
		.shadow_op (shadow_op),
		.response  (response)
	);

	board_shadow #(.NUM_ROWS(NUM_ROWS), .NUM_COLS(NUM_COLS)) u_board_shadow
	(
		.clk       (clk),
		.reset     (reset),
		.shadow_op (shadow_op),
		.data_in   (data_in),
		.board     (board)
	);

	win_detect #(.NUM_ROWS(NUM_ROWS), .NUM_COLS(NUM_COLS)) u_win_detect
	(
		.clk    (clk),
		.reset  (reset),
		.board  (board),
		.p1_win (p1_win),
		.p2_win (p2_win)
	);

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 8
)
(
	output logic      clk,
	output logic      reset,
	input  wire logic reset_req	// starts a fresh reset pulse
);

	int hold = RESET_CYCLES;	// reset cycles still to go

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (reset_req)
			hold <= RESET_CYCLES;
		else if (hold > 0)
			hold <= hold - 1;
	end

	assign reset = (hold == 0);

endmodule

`default_nettype wire

//--- tb/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top
	import game_pkg::*, mem_pkg::*;
();

	localparam int NUM_ROWS  = 6;
	localparam int NUM_COLS  = 7;
	localparam int NUM_CELLS = NUM_ROWS * NUM_COLS;
	localparam int ROW_W     = 2 * NUM_COLS;

	// worst case per move is a read per row, one write and one full won sweep
	localparam int MAX_MOVES    = 240;
	localparam int TXN_PER_MOVE = NUM_ROWS + 1 + NUM_CELLS;
	localparam int TXN_CYCLES   = 8;	// config, up to 4 wait, check
	localparam int NUM_RESETS   = 10;
	localparam int LIMIT        =
		(MAX_MOVES * TXN_PER_MOVE + NUM_RESETS * (NUM_CELLS + 8)) * TXN_CYCLES;

	typedef struct packed
	{
		logic  full;
		addr_t target;
		cell_t winner;
	} ref_res_t;

	logic             clk;
	logic             reset;
	logic             reset_req = 1'b0;
	logic             active    = 1'b0;
	move_t            move      = '0;
	logic             ready     = 1'b0;
	logic [ROW_W-1:0] data_in   = '0;
	mem_req_t         mem_req;
	resp_t            response;

	cell_t                  mem [NUM_CELLS];
	logic                   busy  = 1'b0;
	int                     delay = 0;
	logic [2*NUM_CELLS-1:0] ref_board = '0;	// expected board in the memory layout
	mem_req_t               exp_wr [$];
	resp_t                  exp_resp [$];
	logic                   quiet = 1'b0;	// no traffic allowed while the game is locked
	int                     resp_seen = 0;
	int                     errors = 0;
	int                     checks = 0;
	int                     err_mark = 0;
	int                     tests = 0;
	int                     tests_bad = 0;

	tb_clock #(.PERIOD(20), .RESET_CYCLES(8)) u_clock
	(
		.clk       (clk),
		.reset     (reset),
		.reset_req (reset_req)
	);

	connect4_top #(.NUM_ROWS(NUM_ROWS), .NUM_COLS(NUM_COLS)) DUT
	(
		.clk      (clk),
		.reset    (reset),
		.active   (active),
		.move     (move),
		.ready    (ready),
		.data_in  (data_in),
		.mem_req  (mem_req),
		.response (response)
	);

	////////////////////////////////////////////////////////////
	// row memory answering after 1 to 4 cycles

	initial
		for (int i = 0; i < NUM_CELLS; i++)
			mem[i] = cell_t'((i % 3) + 1);	// garbage until the clear sweep

	always @(posedge clk)
	begin
		ready <= 1'b0;
		if (!reset)
			busy <= 1'b0;
		else if (busy)
		begin
			if (delay > 0)
				delay <= delay - 1;
			else
			begin
				busy  <= 1'b0;
				ready <= 1'b1;
				if (mem_req.wren && int'(mem_req.addr) < NUM_CELLS)
					mem[mem_req.addr] <= mem_req.data;
				else if (mem_req.rden)
					for (int c = 0; c < NUM_COLS; c++)
						data_in[2*c +: 2] <= mem[int'(mem_req.addr) + c];
			end
		end
		else if ((mem_req.rden || mem_req.wren) && !ready)
		begin
			busy  <= 1'b1;
			delay <= int'($urandom_range(3, 0));
		end
	end

	////////////////////////////////////////////////////////////
	// reference model

	function automatic ref_res_t ref_move(input logic [2*NUM_CELLS-1:0] b, input move_t m);
		ref_res_t res;
		int       dr [4];
		int       dc [4];
		int       rr;
		int       cc;
		int       run;
		cell_t    first;
		dr = '{0, 1, 1, 1};
		dc = '{1, 0, 1, -1};	// right, down, down-right, down-left
		res.full   = 1'b1;
		res.target = '0;
		res.winner = CELL_EMPTY;
		for (int r = NUM_ROWS - 1; r >= 0; r--)
		begin
			if (res.full && b[2*(r*NUM_COLS + int'(m.col)) +: 2] == CELL_EMPTY)
			begin
				res.full   = 1'b0;	// lowest free cell
				res.target = addr_t'(r*NUM_COLS + int'(m.col));
			end
		end
		if (!res.full)
			b[2*int'(res.target) +: 2] = m.player;
		for (int s = 0; s < NUM_CELLS; s++)
		begin
			first = b[2*s +: 2];
			for (int d = 0; d < 4; d++)
			begin
				run = 0;
				for (int k = 0; k < 4; k++)
				begin
					rr = s / NUM_COLS + k * dr[d];
					cc = s % NUM_COLS + k * dc[d];
					if (rr < NUM_ROWS && cc >= 0 && cc < NUM_COLS)
					begin
						if (b[2*(rr*NUM_COLS + cc) +: 2] == first)
							run++;
					end
				end
				if (first != CELL_EMPTY && run == 4)
					res.winner = first;
			end
		end
		return res;
	endfunction

	function automatic mem_req_t write_req(input addr_t a, input cell_t d);
		mem_req_t req;
		req      = '0;
		req.addr = a;
		req.data = d;
		return req;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	////////////////////////////////////////////////////////////
	// compare on the falling edge

	always @(negedge clk)
	begin
		mem_req_t exp_req;
		resp_t    exp_r;
		if (reset)
		begin
			if (quiet && (mem_req.rden || mem_req.wren || response != RESP_NONE))
			begin
				errors++;
				$display("Memory traffic or a response while the game is locked at %0t", $time);
			end
			if (ready && mem_req.wren)
			begin
				if (exp_wr.size() == 0)
				begin
					errors++;
					$display("Memory write to address %0d when none was expected", mem_req.addr);
				end
				else
				begin
					exp_req = exp_wr.pop_front();
					check_value("mem_req.addr", mem_req.addr, exp_req.addr);
					check_value("mem_req.data", mem_req.data, exp_req.data);
				end
			end
			if (response != RESP_NONE)
			begin
				resp_seen++;
				if (exp_resp.size() == 0)
				begin
					errors++;
					$display("Response %0d when no move was pending", response);
				end
				else
				begin
					exp_r = exp_resp.pop_front();
					check_value("response", response, exp_r);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus

	task automatic wait_drained();
		while (exp_wr.size() != 0 || exp_resp.size() != 0)
			@(posedge clk);
	endtask

	task automatic restart_game();
		quiet     = 1'b0;
		ref_board = '0;
		for (int i = 0; i < NUM_CELLS; i++)
			exp_wr.push_back(write_req(addr_t'(i), CELL_EMPTY));
		@(posedge clk);
		reset_req <= 1'b1;
		@(posedge clk);
		reset_req <= 1'b0;
		wait_drained();
	endtask

	task automatic play_move(input col_t col, input cell_t player, output cell_t winner);
		ref_res_t res;
		move_t    m;
		int       seen;
		m.col    = col;
		m.player = player;
		res = ref_move(ref_board, m);
		if (res.full)
			exp_resp.push_back(RESP_REJECT);
		else
		begin
			exp_wr.push_back(write_req(res.target, player));
			exp_resp.push_back(RESP_ACCEPT);
			ref_board[2*int'(res.target) +: 2] = player;
		end
		if (res.winner != CELL_EMPTY)
			for (int i = 0; i < NUM_CELLS; i++)
				exp_wr.push_back(write_req(addr_t'(i), res.winner));	// won sweep
		seen = resp_seen;
		@(posedge clk);
		active <= 1'b1;
		move   <= m;
		while (resp_seen == seen)
			@(posedge clk);
		active <= 1'b0;		// dropped before the FSM is back in idle
		wait_drained();
		winner = res.winner;
	endtask

	task automatic probe_lock();
		quiet = 1'b1;
		@(posedge clk);
		active <= 1'b1;
		move   <= '{col: 3'd2, player: CELL_P1};
		repeat (6) @(posedge clk);
		active <= 1'b0;
		repeat (12) @(posedge clk);
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == err_mark)
			$display("%s: ok", name);
		else
		begin
			tests_bad++;
			$display("%s: %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// one column per nibble from the top and nibble F ends the list
	task automatic play_line(input string name, input logic [47:0] seq);
		logic [3:0] nib;
		cell_t      player;
		cell_t      winner;
		restart_game();
		player = CELL_P1;
		winner = CELL_EMPTY;
		for (int i = 0; i < 12; i++)
		begin
			nib = seq[47 - 4*i -: 4];
			if (nib == 4'hF || winner != CELL_EMPTY)
				break;
			play_move(col_t'(nib), player, winner);
			player = (player == CELL_P1) ? CELL_P2 : CELL_P1;
		end
		for (int i = 0; i < NUM_CELLS; i++)
			check_value($sformatf("mem[%0d]", i), mem[i], winner);	// painted by the won sweep
		probe_lock();
		finish_test(name);
	endtask

	initial
	begin
		cell_t player;
		cell_t winner;
		col_t  col;
		int    moves;
		void'($urandom(37));
		restart_game();
		for (int i = 0; i < NUM_CELLS; i++)
			check_value($sformatf("mem[%0d]", i), mem[i], CELL_EMPTY);
		finish_test("clear sweep");

		play_move(3'd3, CELL_P1, winner);
		play_move(3'd3, CELL_P2, winner);
		finish_test("legal moves");

		player = CELL_P1;
		for (int i = 0; i <= NUM_ROWS; i++)	// the seventh is refused
		begin
			play_move(3'd0, player, winner);
			player = (player == CELL_P1) ? CELL_P2 : CELL_P1;
		end
		finish_test("full column");

		play_line("horizontal four", 48'h0011223FFFFF);
		play_line("vertical four", 48'h01210131FFFF);	// second player wins
		play_line("rising four", 48'h01122323363F);
		play_line("falling four", 48'h65544343303F);

		for (int g = 0; g < 4; g++)
		begin
			restart_game();
			player = CELL_P1;
			winner = CELL_EMPTY;
			moves  = 0;
			while (winner == CELL_EMPTY && moves < NUM_CELLS)
			begin
				do
					col = col_t'($urandom_range(NUM_COLS - 1, 0));
				while (ref_board[2*int'(col) +: 2] != CELL_EMPTY);	// top cell taken
				play_move(col, player, winner);
				player = (player == CELL_P1) ? CELL_P2 : CELL_P1;
				moves++;
			end
			if (winner != CELL_EMPTY)
				probe_lock();
			finish_test($sformatf("random game %0d, %0d moves", g, moves));
		end

		$display("tests %0d, bad %0d, checks %0d, errors %0d", tests, tests_bad, checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		repeat (LIMIT) @(posedge clk);
		$display("Timeout after %0d clock cycles, the run did not finish", LIMIT);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
design/game_pkg.sv
design/mem_pkg.sv
design/move_fsm.sv
design/board_shadow.sv
design/win_detect.sv
design/connect4_top.sv
tb/tb_clock.sv
tb/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# builds the Connect Four testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f list.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	echo "simulation reported a failure, see $LOG"
	exit 1
fi

exit 0
